//--- include/issue_cfg_cfg.svh
// width and count settings of the integer issue stage, included by the package and every RTL file
`ifndef ISSUE_CFG_CFG_SVH
`define ISSUE_CFG_CFG_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------

// integer data width
`define ISSUE_XLEN 32

// program counter width
`define ISSUE_VLEN 32

// ------------------------------------------------------------
// register file
// ------------------------------------------------------------

// architectural integer registers, x0 included
`define ISSUE_NR_REGS 32

// register address width, log2 of the register count
`define ISSUE_REG_ADDR_W 5

// write ports driven by the commit stage
`define ISSUE_NR_COMMIT 2

// ------------------------------------------------------------
// scoreboard
// ------------------------------------------------------------

// transaction id width
`define ISSUE_TRANS_ID_W 3

`endif

//--- verilog/issue_pkg.sv
// shared enums and packed structs of the integer issue stage, referenced by scoped name
`include "issue_cfg_cfg.svh"

package issue_pkg;

  // ------------------------------------------------------------
  // functional units and operations
  // ------------------------------------------------------------

  // target unit of an instruction, also used in the clobber table
  typedef enum logic [2:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR
  } fu_t;

  // operation subset seen by this stage, ADD is the reset value
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND_OP,
    OR_OP,
    SLL,
    BEQ,
    JAL,
    LW,
    SW,
    MUL,
    CSR_RW,
    SFENCE_VMA
  } fu_op_t;

  // ------------------------------------------------------------
  // decoder to issue
  // ------------------------------------------------------------

  // decoded scoreboard entry
  typedef struct packed {
    logic [`ISSUE_VLEN-1:0]       pc;
    logic [`ISSUE_TRANS_ID_W-1:0] trans_id;
    fu_t                          fu;
    fu_op_t                       op;
    logic [`ISSUE_REG_ADDR_W-1:0] rs1;
    logic [`ISSUE_REG_ADDR_W-1:0] rs2;
    logic [`ISSUE_REG_ADDR_W-1:0] rd;
    // immediate from the decoder
    logic [`ISSUE_XLEN-1:0]       result;
    // exception already raised upstream
    logic                         ex_valid;
    logic                         use_imm;
    logic                         use_zimm;
    logic                         use_pc;
    logic                         is_compressed;
  } issue_entry_t;

  // ------------------------------------------------------------
  // scoreboard and commit side
  // ------------------------------------------------------------

  // forwarding answer for one source register
  typedef struct packed {
    logic                   valid;
    logic [`ISSUE_XLEN-1:0] data;
  } fwd_port_t;

  // one register file write from commit
  typedef struct packed {
    logic                         we;
    logic [`ISSUE_REG_ADDR_W-1:0] waddr;
    logic [`ISSUE_XLEN-1:0]       wdata;
  } commit_port_t;

  // ------------------------------------------------------------
  // issue to functional units
  // ------------------------------------------------------------

  // operands and control handed to the units
  typedef struct packed {
    fu_t                          fu;
    fu_op_t                       op;
    logic [`ISSUE_TRANS_ID_W-1:0] trans_id;
    logic [`ISSUE_XLEN-1:0]       operand_a;
    logic [`ISSUE_XLEN-1:0]       operand_b;
    logic [`ISSUE_XLEN-1:0]       imm;
  } fu_data_t;

  // one valid per unit, at most one set
  typedef struct packed {
    logic alu;
    logic branch;
    logic lsu;
    logic mult;
    logic csr;
  } fu_valid_t;

  // forward instead of register file read
  typedef struct packed {
    logic rs1;
    logic rs2;
  } fwd_sel_t;

endpackage

//--- verilog/gpr_regfile.sv
// integer register file with two combinational read ports and the commit write ports
`timescale 1ns/1ps
`include "issue_cfg_cfg.svh"

module gpr_regfile (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic [`ISSUE_REG_ADDR_W-1:0]                    raddr_a_i,
  input  logic [`ISSUE_REG_ADDR_W-1:0]                    raddr_b_i,
  output logic [`ISSUE_XLEN-1:0]                          rdata_a_o,
  output logic [`ISSUE_XLEN-1:0]                          rdata_b_o,
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0]  commit_i
);

  logic [`ISSUE_XLEN-1:0] mem_q [`ISSUE_NR_REGS];

  // ------------------------------------------------------------
  // write side
  // ------------------------------------------------------------

  // all ports write at the same edge, x0 never written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < `ISSUE_NR_REGS; r++) begin
        mem_q[r] <= '0;
      end
    end else begin
      for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
        if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
          mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // read side
  // ------------------------------------------------------------

  // no bypass of same-cycle writes, visible one cycle later
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

  // commit never retires two writers of one register together
  for (genvar i = 0; i < `ISSUE_NR_COMMIT; i++) begin : gen_port_a
    for (genvar j = i + 1; j < `ISSUE_NR_COMMIT; j++) begin : gen_port_b
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(commit_i[i].we && commit_i[j].we && (commit_i[i].waddr != '0) &&
          (commit_i[i].waddr == commit_i[j].waddr)))
        else $error("commit ports %0d and %0d write the same register", i, j);
    end
  end

endmodule

//--- verilog/hazard_check.sv
// operand availability, unit busy and WAW checks that produce the issue acknowledge
`timescale 1ns/1ps
`include "issue_cfg_cfg.svh"

module hazard_check (
  input  issue_pkg::issue_entry_t                         issue_entry_i,
  input  logic                                            issue_valid_i,
  input  issue_pkg::fu_t [`ISSUE_NR_REGS-1:0]             rd_clobber_i,
  input  issue_pkg::fwd_port_t                            fwd_rs1_i,
  input  issue_pkg::fwd_port_t                            fwd_rs2_i,
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0]  commit_i,
  input  logic                                            flu_ready_i,
  input  logic                                            lsu_ready_i,
  input  logic                                            stall_i,
  input  logic                                            mult_pending_i,
  output issue_pkg::fwd_sel_t                             fwd_sel_o,
  output logic                                            stall_issue_o,
  output logic                                            issue_ack_o
);

  issue_pkg::fu_t rs1_owner;
  issue_pkg::fu_t rs2_owner;
  logic           operand_stall;
  logic           fu_busy;
  logic           rd_free;

  // scoreboard owners of the sources
  assign rs1_owner = rd_clobber_i[issue_entry_i.rs1];
  assign rs2_owner = rd_clobber_i[issue_entry_i.rs2];

  // ------------------------------------------------------------
  // source operands
  // ------------------------------------------------------------

  // in-flight owner means forward or wait
  // CSR results only come through the register file, sfence excepted
  always_comb begin : operand_check
    fwd_sel_o     = '0;
    operand_stall = 1'b0;
    // zimm uses the rs1 field as data, nothing to wait for
    if (!issue_entry_i.use_zimm && (rs1_owner != issue_pkg::NONE)) begin
      if (fwd_rs1_i.valid && ((rs1_owner != issue_pkg::CSR) ||
                              (issue_entry_i.op == issue_pkg::SFENCE_VMA))) begin
        fwd_sel_o.rs1 = 1'b1;
      end else begin
        operand_stall = 1'b1;
      end
    end
    if (rs2_owner != issue_pkg::NONE) begin
      if (fwd_rs2_i.valid && ((rs2_owner != issue_pkg::CSR) ||
                              (issue_entry_i.op == issue_pkg::SFENCE_VMA))) begin
        fwd_sel_o.rs2 = 1'b1;
      end else begin
        operand_stall = 1'b1;
      end
    end
  end

  assign stall_issue_o = stall_i | operand_stall;

  // ------------------------------------------------------------
  // unit busy
  // ------------------------------------------------------------

  // lsu has its own ready, all others share the flu ready
  always_comb begin : unit_busy
    unique case (issue_entry_i.fu)
      issue_pkg::NONE:                    fu_busy = 1'b0;
      issue_pkg::LOAD, issue_pkg::STORE:  fu_busy = ~lsu_ready_i;
      default:                            fu_busy = ~flu_ready_i;
    endcase
  end

  // ------------------------------------------------------------
  // WAW and acknowledge
  // ------------------------------------------------------------

  // rd free, or its current owner commits this very cycle
  always_comb begin : waw_check
    rd_free = (rd_clobber_i[issue_entry_i.rd] == issue_pkg::NONE);
    for (int unsigned p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      if (commit_i[p].we && (commit_i[p].waddr == issue_entry_i.rd)) begin
        rd_free = 1'b1;
      end
    end
  end

  always_comb begin : issue_ack
    issue_ack_o = 1'b0;
    if (issue_valid_i) begin
      if (!stall_issue_o && !fu_busy && rd_free) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less entries pass straight through
      if (issue_entry_i.ex_valid || (issue_entry_i.fu == issue_pkg::NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // multiplier result owns the fixed latency writeback next cycle
    if (mult_pending_i && (issue_entry_i.fu inside
        {issue_pkg::ALU, issue_pkg::CTRL_FLOW, issue_pkg::CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

endmodule

//--- verilog/operand_select.sv
// combinational operand mux from register file, forward path, pc, zimm and immediate
`timescale 1ns/1ps
`include "issue_cfg_cfg.svh"

module operand_select (
  input  issue_pkg::issue_entry_t  issue_entry_i,
  input  logic [`ISSUE_XLEN-1:0]   rdata_a_i,
  input  logic [`ISSUE_XLEN-1:0]   rdata_b_i,
  input  issue_pkg::fwd_port_t     fwd_rs1_i,
  input  issue_pkg::fwd_port_t     fwd_rs2_i,
  input  issue_pkg::fwd_sel_t      fwd_sel_i,
  output issue_pkg::fu_data_t      operands_o
);

  // ------------------------------------------------------------
  // operand mux
  // ------------------------------------------------------------

  // later assignments take priority
  always_comb begin : operand_mux
    operands_o.fu       = issue_entry_i.fu;
    operands_o.op       = issue_entry_i.op;
    operands_o.trans_id = issue_entry_i.trans_id;
    // stores and branches take the immediate from here
    operands_o.imm      = issue_entry_i.result;

    // operand a
    operands_o.operand_a = rdata_a_i;
    if (fwd_sel_i.rs1) begin
      operands_o.operand_a = fwd_rs1_i.data;
    end
    // auipc and jal style
    if (issue_entry_i.use_pc) begin
      operands_o.operand_a = `ISSUE_XLEN'(issue_entry_i.pc);
    end
    // csr immediate, rs1 field zero extended
    if (issue_entry_i.use_zimm) begin
      operands_o.operand_a = `ISSUE_XLEN'(issue_entry_i.rs1);
    end

    // operand b
    operands_o.operand_b = rdata_b_i;
    if (fwd_sel_i.rs2) begin
      operands_o.operand_b = fwd_rs2_i.data;
    end
    // store data and branch compare keep rs2 in operand b
    if (issue_entry_i.use_imm && (issue_entry_i.fu != issue_pkg::STORE) &&
        (issue_entry_i.fu != issue_pkg::CTRL_FLOW)) begin
      operands_o.operand_b = issue_entry_i.result;
    end
  end

endmodule

//--- verilog/issue_regs.sv
// ID/EX pipeline register with one valid pulse per unit, cleared on flush
`timescale 1ns/1ps
`include "issue_cfg_cfg.svh"

module issue_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  issue_pkg::fu_data_t      operands_i,
  input  logic                     issue_fire_i,
  input  issue_pkg::issue_entry_t  issue_entry_i,
  output issue_pkg::fu_data_t      fu_data_o,
  output issue_pkg::fu_valid_t     fu_valid_o,
  output logic [`ISSUE_VLEN-1:0]   pc_o,
  output logic                     is_compressed_o
);

  // ------------------------------------------------------------
  // payload
  // ------------------------------------------------------------

  // loads every cycle, the valids qualify it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fu_data_o       <= '{fu: issue_pkg::NONE, op: issue_pkg::ADD, default: '0};
      pc_o            <= '0;
      is_compressed_o <= 1'b0;
    end else begin
      fu_data_o       <= operands_i;
      pc_o            <= issue_entry_i.pc;
      is_compressed_o <= issue_entry_i.is_compressed;
    end
  end

  // ------------------------------------------------------------
  // unit valids
  // ------------------------------------------------------------

  // one cycle pulse per issued entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fu_valid_o <= '0;
    end else begin
      fu_valid_o <= '0;
      // excepted entries are only retired, never executed
      if (issue_fire_i && !issue_entry_i.ex_valid) begin
        unique case (issue_entry_i.fu)
          issue_pkg::ALU:                    fu_valid_o.alu    <= 1'b1;
          issue_pkg::CTRL_FLOW:              fu_valid_o.branch <= 1'b1;
          issue_pkg::LOAD, issue_pkg::STORE: fu_valid_o.lsu    <= 1'b1;
          issue_pkg::MULT:                   fu_valid_o.mult   <= 1'b1;
          issue_pkg::CSR:                    fu_valid_o.csr    <= 1'b1;
          default: ;
        endcase
      end
      // flush wins, units would start on squashed operands
      if (flush_i) begin
        fu_valid_o <= '0;
      end
    end
  end

  // at most one unit started per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(fu_valid_o))
    else $error("more than one unit valid");

endmodule

//--- verilog/issue_top.sv
// integer issue and operand-read stage, between the decoder and the functional units
`timescale 1ns/1ps
`include "issue_cfg_cfg.svh"

module issue_top (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            stall_i,
  input  issue_pkg::issue_entry_t                         issue_entry_i,
  input  logic                                            issue_valid_i,
  output logic                                            issue_ack_o,
  output logic [`ISSUE_REG_ADDR_W-1:0]                    rs1_o,
  output logic [`ISSUE_REG_ADDR_W-1:0]                    rs2_o,
  input  issue_pkg::fwd_port_t                            fwd_rs1_i,
  input  issue_pkg::fwd_port_t                            fwd_rs2_i,
  input  issue_pkg::fu_t [`ISSUE_NR_REGS-1:0]             rd_clobber_i,
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0]  commit_i,
  input  logic                                            flu_ready_i,
  input  logic                                            lsu_ready_i,
  output issue_pkg::fu_data_t                             fu_data_o,
  output issue_pkg::fu_valid_t                            fu_valid_o,
  output logic [`ISSUE_VLEN-1:0]                          pc_o,
  output logic                                            is_compressed_o,
  output logic                                            stall_issue_o
);

  logic [`ISSUE_XLEN-1:0] rdata_a;
  logic [`ISSUE_XLEN-1:0] rdata_b;
  issue_pkg::fwd_sel_t    fwd_sel;
  issue_pkg::fu_data_t    operands;
  logic                   issue_fire;

  // scoreboard lookup straight from the entry
  assign rs1_o = issue_entry_i.rs1;
  assign rs2_o = issue_entry_i.rs2;

  // entry consumed by the stage
  assign issue_fire = issue_valid_i & issue_ack_o;

  // ------------------------------------------------------------
  // operand read
  // ------------------------------------------------------------

  gpr_regfile i_gpr_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_entry_i.rs1),
    .raddr_b_i (issue_entry_i.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .commit_i  (commit_i)
  );

  // registered mult valid blocks ALU, branch and CSR for one cycle
  hazard_check i_hazard_check (
    .issue_entry_i  (issue_entry_i),
    .issue_valid_i  (issue_valid_i),
    .rd_clobber_i   (rd_clobber_i),
    .fwd_rs1_i      (fwd_rs1_i),
    .fwd_rs2_i      (fwd_rs2_i),
    .commit_i       (commit_i),
    .flu_ready_i    (flu_ready_i),
    .lsu_ready_i    (lsu_ready_i),
    .stall_i        (stall_i),
    .mult_pending_i (fu_valid_o.mult),
    .fwd_sel_o      (fwd_sel),
    .stall_issue_o  (stall_issue_o),
    .issue_ack_o    (issue_ack_o)
  );

  operand_select i_operand_select (
    .issue_entry_i (issue_entry_i),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .fwd_rs1_i     (fwd_rs1_i),
    .fwd_rs2_i     (fwd_rs2_i),
    .fwd_sel_i     (fwd_sel),
    .operands_o    (operands)
  );

  // ------------------------------------------------------------
  // ID/EX boundary
  // ------------------------------------------------------------

  issue_regs i_issue_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .operands_i      (operands),
    .issue_fire_i    (issue_fire),
    .issue_entry_i   (issue_entry_i),
    .fu_data_o       (fu_data_o),
    .fu_valid_o      (fu_valid_o),
    .pc_o            (pc_o),
    .is_compressed_o (is_compressed_o)
  );

endmodule

//--- test/tb_issue.sv
// directed testbench of the integer issue stage, drives issue_top through its handshakes
`timescale 1ns/1ps
`include "issue_cfg_cfg.svh"

module tb_issue;

  localparam int NUM_TESTS      = 6;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;

  localparam issue_pkg::fu_valid_t VALID_NONE = '0;
  localparam issue_pkg::fu_valid_t VALID_ALU  = '{alu: 1'b1, default: 1'b0};
  localparam issue_pkg::fu_valid_t VALID_LSU  = '{lsu: 1'b1, default: 1'b0};
  localparam issue_pkg::fu_valid_t VALID_MULT = '{mult: 1'b1, default: 1'b0};
  localparam issue_pkg::fu_valid_t VALID_CSR  = '{csr: 1'b1, default: 1'b0};

  logic                                           clk_i;
  logic                                           rst_ni;
  logic                                           flush;
  logic                                           stall;
  issue_pkg::issue_entry_t                        entry;
  logic                                           issue_valid;
  logic                                           issue_ack;
  logic [`ISSUE_REG_ADDR_W-1:0]                   rs1;
  logic [`ISSUE_REG_ADDR_W-1:0]                   rs2;
  issue_pkg::fwd_port_t                           fwd_rs1;
  issue_pkg::fwd_port_t                           fwd_rs2;
  issue_pkg::fu_t [`ISSUE_NR_REGS-1:0]            rd_clobber;
  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit;
  logic                                           flu_ready;
  logic                                           lsu_ready;
  issue_pkg::fu_data_t                            fu_data;
  issue_pkg::fu_valid_t                           fu_valid;
  logic [`ISSUE_VLEN-1:0]                         pc;
  logic                                           is_compressed;
  logic                                           stall_issue;

  // reference copy of the architectural registers
  logic [`ISSUE_XLEN-1:0] ref_regs [`ISSUE_NR_REGS];
  logic [31:0]            rng_state;
  int                     errors;
  int                     checks;

  issue_top i_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush),
    .stall_i         (stall),
    .issue_entry_i   (entry),
    .issue_valid_i   (issue_valid),
    .issue_ack_o     (issue_ack),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .fwd_rs1_i       (fwd_rs1),
    .fwd_rs2_i       (fwd_rs2),
    .rd_clobber_i    (rd_clobber),
    .commit_i        (commit),
    .flu_ready_i     (flu_ready),
    .lsu_ready_i     (lsu_ready),
    .fu_data_o       (fu_data),
    .fu_valid_o      (fu_valid),
    .pc_o            (pc),
    .is_compressed_o (is_compressed),
    .stall_issue_o   (stall_issue)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // plain entry, random pc, immediate and id, all flags clear
  function automatic issue_pkg::issue_entry_t make_entry(input issue_pkg::fu_t fu,
      input issue_pkg::fu_op_t op, input logic [`ISSUE_REG_ADDR_W-1:0] a,
      input logic [`ISSUE_REG_ADDR_W-1:0] b, input logic [`ISSUE_REG_ADDR_W-1:0] d);
    issue_pkg::issue_entry_t e;
    e          = '0;
    e.fu       = fu;
    e.op       = op;
    e.rs1      = a;
    e.rs2      = b;
    e.rd       = d;
    e.pc       = rand_word();
    e.result   = rand_word();
    e.trans_id = `ISSUE_TRANS_ID_W'(rand_word());
    return e;
  endfunction

  // expectation with both operands from the reference registers
  function automatic issue_pkg::fu_data_t reg_operands(input issue_pkg::issue_entry_t e);
    issue_pkg::fu_data_t d;
    d.fu        = e.fu;
    d.op        = e.op;
    d.trans_id  = e.trans_id;
    d.operand_a = ref_regs[e.rs1];
    d.operand_b = ref_regs[e.rs2];
    d.imm       = e.result;
    return d;
  endfunction

  task automatic check_fu_data(input string name, input issue_pkg::fu_data_t got,
      input issue_pkg::fu_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_fu_valid(input string name, input issue_pkg::fu_valid_t got,
      input issue_pkg::fu_valid_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_reg_addr(input string name, input logic [`ISSUE_REG_ADDR_W-1:0] got,
      input logic [`ISSUE_REG_ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_pc(input string name, input logic [`ISSUE_VLEN-1:0] got,
      input logic [`ISSUE_VLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  // quiet inputs, all units ready, nothing in flight
  task automatic set_idle();
    issue_valid <= 1'b0;
    flush       <= 1'b0;
    stall       <= 1'b0;
    flu_ready   <= 1'b1;
    lsu_ready   <= 1'b1;
    fwd_rs1     <= '0;
    fwd_rs2     <= '0;
    commit      <= '0;
    for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
      rd_clobber[i] <= issue_pkg::NONE;
    end
  endtask

  // present an entry for one cycle, caller may override side inputs after
  task automatic drive(input issue_pkg::issue_entry_t e);
    @(posedge clk_i);
    set_idle();
    entry       <= e;
    issue_valid <= 1'b1;
  endtask

  // preload through commit port 0
  task automatic write_reg(input logic [`ISSUE_REG_ADDR_W-1:0] a,
      input logic [`ISSUE_XLEN-1:0] d);
    @(posedge clk_i);
    set_idle();
    commit[0] <= '{we: 1'b1, waddr: a, wdata: d};
    if (a != '0) begin
      ref_regs[a] = d;
    end
  endtask

  // ack in this cycle, unit valid and operands one cycle later
  task automatic finish_issue(input logic exp_ack, input issue_pkg::fu_valid_t exp_valid,
      input issue_pkg::fu_data_t exp_data);
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack, exp_ack);
    // scoreboard lookup addresses come straight from the entry
    check_reg_addr("rs1_o", rs1, entry.rs1);
    check_reg_addr("rs2_o", rs2, entry.rs2);
    @(posedge clk_i);
    set_idle();
    @(negedge clk_i);
    check_fu_valid("fu_valid_o", fu_valid, exp_valid);
    if (exp_valid != VALID_NONE) begin
      check_fu_data("fu_data_o", fu_data, exp_data);
    end
    // pc and compressed flag are registered whether or not the entry fired
    check_pc("pc_o", pc, entry.pc);
    check_bit("is_compressed_o", is_compressed, entry.is_compressed);
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------

  task automatic reset_and_read();
    issue_pkg::issue_entry_t e;
    issue_pkg::fu_data_t     exp;
    @(negedge clk_i);
    check_fu_valid("fu_valid_o", fu_valid, VALID_NONE);
    check_fu_data("fu_data_o", fu_data, '{fu: issue_pkg::NONE, op: issue_pkg::ADD, default: '0});
    write_reg(5'd1, rand_word());
    write_reg(5'd2, rand_word());
    e = make_entry(issue_pkg::ALU, issue_pkg::ADD, 5'd1, 5'd2, 5'd3);
    drive(e);
    finish_issue(1'b1, VALID_ALU, reg_operands(e));
    // x0 reads as zero
    e = make_entry(issue_pkg::ALU, issue_pkg::ADD, 5'd0, 5'd2, 5'd3);
    exp = reg_operands(e);
    exp.operand_a = '0;
    drive(e);
    finish_issue(1'b1, VALID_ALU, exp);
  endtask

  task automatic forward_or_stall();
    issue_pkg::issue_entry_t e;
    issue_pkg::fu_data_t     exp;
    logic [`ISSUE_XLEN-1:0]  fdata;
    fdata = rand_word();
    e = make_entry(issue_pkg::ALU, issue_pkg::ADD, 5'd1, 5'd2, 5'd4);
    exp = reg_operands(e);
    exp.operand_a = fdata;
    drive(e);
    rd_clobber[1] <= issue_pkg::ALU;
    fwd_rs1       <= '{valid: 1'b1, data: fdata};
    finish_issue(1'b1, VALID_ALU, exp);
    // owner still computing
    drive(e);
    rd_clobber[1] <= issue_pkg::ALU;
    @(negedge clk_i);
    check_bit("stall_issue_o", stall_issue, 1'b1);
    finish_issue(1'b0, VALID_NONE, exp);
    // CSR result cannot be forwarded
    drive(e);
    rd_clobber[2] <= issue_pkg::CSR;
    fwd_rs2       <= '{valid: 1'b1, data: fdata};
    @(negedge clk_i);
    check_bit("stall_issue_o", stall_issue, 1'b1);
    finish_issue(1'b0, VALID_NONE, exp);
    // sfence is exempt
    e = make_entry(issue_pkg::CSR, issue_pkg::SFENCE_VMA, 5'd1, 5'd2, 5'd0);
    exp = reg_operands(e);
    exp.operand_b = fdata;
    drive(e);
    rd_clobber[2] <= issue_pkg::CSR;
    fwd_rs2       <= '{valid: 1'b1, data: fdata};
    finish_issue(1'b1, VALID_CSR, exp);
  endtask

  task automatic waw_hazard();
    issue_pkg::issue_entry_t e;
    logic [`ISSUE_XLEN-1:0]  wdata;
    wdata = rand_word();
    e = make_entry(issue_pkg::ALU, issue_pkg::SUB, 5'd1, 5'd2, 5'd5);
    drive(e);
    rd_clobber[5] <= issue_pkg::MULT;
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack, 1'b0);
    // same entry held, owner of rd commits now
    drive(e);
    rd_clobber[5] <= issue_pkg::MULT;
    commit[1]     <= '{we: 1'b1, waddr: 5'd5, wdata: wdata};
    finish_issue(1'b1, VALID_ALU, reg_operands(e));
    ref_regs[5] = wdata;
  endtask

  task automatic operand_sources();
    issue_pkg::issue_entry_t e;
    issue_pkg::fu_data_t     exp;
    e = make_entry(issue_pkg::ALU, issue_pkg::ADD, 5'd1, 5'd2, 5'd6);
    e.use_pc        = 1'b1;
    e.is_compressed = 1'b1;
    exp = reg_operands(e);
    exp.operand_a = e.pc;
    drive(e);
    finish_issue(1'b1, VALID_ALU, exp);
    // zimm ignores the clobber on the rs1 field
    e = make_entry(issue_pkg::CSR, issue_pkg::CSR_RW, 5'h1b, 5'd0, 5'd6);
    e.use_zimm = 1'b1;
    exp = reg_operands(e);
    exp.operand_a = {{(`ISSUE_XLEN-`ISSUE_REG_ADDR_W){1'b0}}, e.rs1};
    drive(e);
    rd_clobber[5'h1b] <= issue_pkg::ALU;
    finish_issue(1'b1, VALID_CSR, exp);
    e = make_entry(issue_pkg::ALU, issue_pkg::OR_OP, 5'd1, 5'd2, 5'd6);
    e.use_imm = 1'b1;
    exp = reg_operands(e);
    exp.operand_b = e.result;
    drive(e);
    finish_issue(1'b1, VALID_ALU, exp);
    // store keeps rs2 as data
    e = make_entry(issue_pkg::STORE, issue_pkg::SW, 5'd1, 5'd2, 5'd0);
    e.use_imm = 1'b1;
    drive(e);
    finish_issue(1'b1, VALID_LSU, reg_operands(e));
    e = make_entry(issue_pkg::LOAD, issue_pkg::LW, 5'd2, 5'd0, 5'd7);
    e.use_imm = 1'b1;
    exp = reg_operands(e);
    exp.operand_b = e.result;
    drive(e);
    finish_issue(1'b1, VALID_LSU, exp);
  endtask

  task automatic backpressure_and_mult();
    issue_pkg::issue_entry_t e;
    issue_pkg::issue_entry_t m;
    e = make_entry(issue_pkg::LOAD, issue_pkg::LW, 5'd1, 5'd0, 5'd8);
    drive(e);
    lsu_ready <= 1'b0;
    finish_issue(1'b0, VALID_NONE, reg_operands(e));
    m = make_entry(issue_pkg::MULT, issue_pkg::MUL, 5'd1, 5'd2, 5'd9);
    e = make_entry(issue_pkg::ALU, issue_pkg::SLL, 5'd2, 5'd1, 5'd10);
    drive(m);
    @(negedge clk_i);
    check_bit("issue_ack_o", issue_ack, 1'b1);
    // ALU right behind the multiply waits one cycle
    drive(e);
    @(negedge clk_i);
    check_fu_valid("fu_valid_o", fu_valid, VALID_MULT);
    check_fu_data("fu_data_o", fu_data, reg_operands(m));
    check_bit("issue_ack_o", issue_ack, 1'b0);
    drive(e);
    finish_issue(1'b1, VALID_ALU, reg_operands(e));
  endtask

  task automatic exception_none_flush();
    issue_pkg::issue_entry_t e;
    e = make_entry(issue_pkg::ALU, issue_pkg::ADD, 5'd1, 5'd2, 5'd11);
    e.ex_valid = 1'b1;
    drive(e);
    rd_clobber[11] <= issue_pkg::ALU;
    finish_issue(1'b1, VALID_NONE, reg_operands(e));
    e = make_entry(issue_pkg::NONE, issue_pkg::ADD, 5'd1, 5'd2, 5'd0);
    drive(e);
    flu_ready <= 1'b0;
    lsu_ready <= 1'b0;
    finish_issue(1'b1, VALID_NONE, reg_operands(e));
    // flush at the dispatch edge squashes the pulse
    e = make_entry(issue_pkg::ALU, issue_pkg::AND_OP, 5'd1, 5'd2, 5'd12);
    drive(e);
    flush <= 1'b1;
    finish_issue(1'b1, VALID_NONE, reg_operands(e));
  endtask

  // ------------------------------------------------------------
  // run control
  // ------------------------------------------------------------

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("watchdog expired before the tests completed");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    rng_state   = 32'h4b47;
    errors      = 0;
    checks      = 0;
    entry       = '0;
    issue_valid = 1'b0;
    flush       = 1'b0;
    stall       = 1'b0;
    flu_ready   = 1'b1;
    lsu_ready   = 1'b1;
    fwd_rs1     = '0;
    fwd_rs2     = '0;
    commit      = '0;
    for (int i = 0; i < `ISSUE_NR_REGS; i++) begin
      rd_clobber[i] = issue_pkg::NONE;
      ref_regs[i]   = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_and_read();
    forward_or_stall();
    waw_hazard();
    operand_sources();
    backpressure_and_mult();
    exception_none_flush();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
verilog/issue_pkg.sv
verilog/gpr_regfile.sv
verilog/hazard_check.sv
verilog/operand_select.sv
verilog/issue_regs.sv
verilog/issue_top.sv
test/tb_issue.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_issue
sim_out=$(./obj_dir/Vtb_issue)
printf '%s\n' "$sim_out"
if printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS'; then
  exit 0
fi
echo "simulation did not pass" >&2
exit 1
